// ==== logic/rm_config.svh ====
`ifndef RM_CONFIG_SVH
`define RM_CONFIG_SVH

// data word width
`define RM_WORD 32

// architectural registers, register 0 reads as zero
`define RM_NREG 16

// register index width
`define RM_REG_AW 4

// one-hot branch context
// all zero means no pending writer
`define RM_CTX_W 4

`endif

// ==== logic/exec_pkg.sv ====
`include "rm_config.svh"

package exec_pkg;

    // opcodes understood by the execution units
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_SLL = 3'd4,
        OP_MUL = 3'd5
    } op_e;

    // request handed to the ALU or the multiplier
    // operands are already forwarded
    typedef struct packed {
        op_e                   op;
        logic [`RM_WORD-1:0]   a;
        logic [`RM_WORD-1:0]   b;
        logic [`RM_REG_AW-1:0] rd;
        logic [`RM_CTX_W-1:0]  ctx;
    } ex_req_t;

endpackage

// ==== logic/reg_types_pkg.sv ====
`include "rm_config.svh"

package reg_types_pkg;

    typedef logic [`RM_REG_AW-1:0] reg_addr_t;
    typedef logic [`RM_WORD-1:0]   word_t;
    typedef logic [`RM_CTX_W-1:0]  ctx_t;

    // one instruction from the issue stage
    typedef struct packed {
        logic          use_rs1;
        reg_addr_t     rs1;
        logic          use_rs2;
        reg_addr_t     rs2;
        logic          use_rd;
        reg_addr_t     rd;
        ctx_t          ctx;
        exec_pkg::op_e op;
    } issue_t;

    // writeback bus, also the result format of both units
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

// ==== logic/reg_file.sv ====
`timescale 1ns/100ps
`include "rm_config.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      rst,
    input  reg_types_pkg::reg_addr_t  rd_addr1,
    input  reg_types_pkg::reg_addr_t  rd_addr2,
    output reg_types_pkg::word_t      rd_data1,
    output reg_types_pkg::word_t      rd_data2,
    input  reg_types_pkg::wb_t        wr
);
    import reg_types_pkg::*;

    word_t regs_q [`RM_NREG];

    // single write port fed from the writeback bus
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RM_NREG; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr.valid && (wr.rd != '0)) begin
            regs_q[wr.rd] <= wr.data;
        end
    end

    // asynchronous reads, register 0 hardwired
    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs_q[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs_q[rd_addr2];

endmodule

// ==== logic/reg_manage.sv ====
`timescale 1ns/100ps
`include "rm_config.svh"

module reg_manage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue,
    input  reg_types_pkg::issue_t     issue_inst,
    input  logic                      branch_hazard,
    input  reg_types_pkg::ctx_t       hazard_ctx,
    input  logic                      alu_free,
    input  reg_types_pkg::wb_t        wb,
    output logic                      accepted,
    output reg_types_pkg::reg_addr_t  rf_addr1,
    output reg_types_pkg::reg_addr_t  rf_addr2,
    input  reg_types_pkg::word_t      rf_data1,
    input  reg_types_pkg::word_t      rf_data2,
    output exec_pkg::ex_req_t         ex_req,
    output logic                      alu_go,
    output logic                      mul_go
);
    import reg_types_pkg::*;
    import exec_pkg::*;

    // context of the pending writer per register
    ctx_t sb_q   [`RM_NREG];
    ctx_t sb_clr [`RM_NREG];
    ctx_t sb_fl  [`RM_NREG];
    ctx_t sb_nxt [`RM_NREG];

    logic  rs1_ok;
    logic  rs2_ok;
    logic  rd_ok;
    logic  ctx_hit;
    logic  is_mul;
    word_t opnd_a;
    word_t opnd_b;

    // write clear first, then the branch flush
    always_comb begin
        for (int i = 0; i < `RM_NREG; i++) begin
            sb_clr[i] = (wb.valid && (wb.rd == reg_addr_t'(i))) ? '0 : sb_q[i];
            sb_fl[i]  = (branch_hazard && (|(sb_clr[i] & hazard_ctx))) ? '0 : sb_clr[i];
        end
    end

    // hazard checks see the scoreboard after clear and flush
    assign rs1_ok  = !issue_inst.use_rs1 || (sb_fl[issue_inst.rs1] == '0);
    assign rs2_ok  = !issue_inst.use_rs2 || (sb_fl[issue_inst.rs2] == '0);
    assign rd_ok   = !issue_inst.use_rd || (sb_fl[issue_inst.rd] == '0);
    assign ctx_hit = branch_hazard && (|(issue_inst.ctx & hazard_ctx));
    assign is_mul  = (issue_inst.op == OP_MUL);

    assign accepted = issue && rs1_ok && rs2_ok && rd_ok && !ctx_hit
                      && (is_mul || alu_free);

    assign alu_go = accepted && !is_mul;
    assign mul_go = accepted && is_mul;

    assign rf_addr1 = issue_inst.rs1;
    assign rf_addr2 = issue_inst.rs2;

    // bypass from this cycle's writeback
    assign opnd_a = (wb.valid && (wb.rd == issue_inst.rs1)) ? wb.data : rf_data1;
    assign opnd_b = (wb.valid && (wb.rd == issue_inst.rs2)) ? wb.data : rf_data2;

    always_comb begin
        ex_req.op  = issue_inst.op;
        ex_req.a   = opnd_a;
        ex_req.b   = opnd_b;
        // no destination, so the result lands on register 0 and is dropped
        ex_req.rd  = issue_inst.use_rd ? issue_inst.rd : '0;
        ex_req.ctx = issue_inst.ctx;
    end

    // reservation last
    always_comb begin
        for (int i = 0; i < `RM_NREG; i++) begin
            sb_nxt[i] = sb_fl[i];
            if (accepted && issue_inst.use_rd && (issue_inst.rd == reg_addr_t'(i))
                && (i != 0)) begin
                sb_nxt[i] = issue_inst.ctx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RM_NREG; i++) begin
                sb_q[i] <= '0;
            end
        end else begin
            sb_q <= sb_nxt;
        end
    end

endmodule

// ==== logic/alu_unit.sv ====
`timescale 1ns/100ps

module alu_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 go,
    input  exec_pkg::ex_req_t    req,
    input  logic                 branch_hazard,
    input  reg_types_pkg::ctx_t  hazard_ctx,
    input  logic                 grant,
    output reg_types_pkg::wb_t   res,
    output logic                 free
);
    import reg_types_pkg::*;
    import exec_pkg::*;

    word_t     result;
    logic      valid_q;
    reg_addr_t rd_q;
    word_t     data_q;
    ctx_t      ctx_q;
    logic      flush_hit;

    always_comb begin
        case (req.op)
            OP_ADD:  result = req.a + req.b;
            OP_SUB:  result = req.a - req.b;
            OP_AND:  result = req.a & req.b;
            OP_XOR:  result = req.a ^ req.b;
            OP_SLL:  result = req.a << req.b[4:0];
            default: result = '0;
        endcase
    end

    assign flush_hit = branch_hazard && (|(ctx_q & hazard_ctx));

    // a granted entry leaves at this edge, so a new one may enter
    assign free = !valid_q || grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (go) begin
            valid_q <= 1'b1;
        end else if (grant || flush_hit) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            rd_q   <= req.rd;
            data_q <= result;
            ctx_q  <= req.ctx;
        end
    end

    assign res = '{valid: valid_q, rd: rd_q, data: data_q};

endmodule

// ==== logic/mul_unit.sv ====
`timescale 1ns/100ps

module mul_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 go,
    input  exec_pkg::ex_req_t    req,
    input  logic                 branch_hazard,
    input  reg_types_pkg::ctx_t  hazard_ctx,
    output reg_types_pkg::wb_t   res
);
    import reg_types_pkg::*;

    // valid and destination per stage
    // context only where a flush can still hit
    logic [2:0] v_q;
    reg_addr_t  rd_q  [3];
    ctx_t       ctx_q [2];
    logic [1:0] kill;

    // operands, product and output copy
    word_t a_q;
    word_t b_q;
    word_t prod_q;
    word_t out_q;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            kill[i] = branch_hazard && (|(ctx_q[i] & hazard_ctx));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v_q <= '0;
        end else begin
            v_q[0] <= go;
            v_q[1] <= v_q[0] && !kill[0];
            v_q[2] <= v_q[1] && !kill[1];
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            a_q      <= req.a;
            b_q      <= req.b;
            rd_q[0]  <= req.rd;
            ctx_q[0] <= req.ctx;
        end
        // low word of the product only
        prod_q   <= a_q * b_q;
        rd_q[1]  <= rd_q[0];
        ctx_q[1] <= ctx_q[0];
        out_q    <= prod_q;
        rd_q[2]  <= rd_q[1];
    end

    assign res = '{valid: v_q[2], rd: rd_q[2], data: out_q};

endmodule

// ==== logic/wb_arbiter.sv ====
`timescale 1ns/100ps

module wb_arbiter (
    input  reg_types_pkg::wb_t  alu_res,
    input  reg_types_pkg::wb_t  mul_res,
    output logic                alu_grant,
    output reg_types_pkg::wb_t  wb
);
    import reg_types_pkg::*;

    wb_t sel;

    // multiplier cannot stall, so it always wins
    assign alu_grant = alu_res.valid && !mul_res.valid;

    always_comb begin
        sel = mul_res.valid ? mul_res : alu_res;
        wb = sel;
        // writes to register 0 never reach the bus
        wb.valid = sel.valid && (sel.rd != '0);
    end

endmodule

// ==== logic/reg_subsys_top.sv ====
`timescale 1ns/100ps

module reg_subsys_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue,
    input  reg_types_pkg::issue_t   issue_inst,
    input  logic                    branch_hazard,
    input  reg_types_pkg::ctx_t     hazard_ctx,
    output logic                    accepted,
    output reg_types_pkg::wb_t      wb
);
    import reg_types_pkg::*;
    import exec_pkg::*;

    reg_addr_t rf_addr1;
    reg_addr_t rf_addr2;
    word_t     rf_data1;
    word_t     rf_data2;
    ex_req_t   ex_req;
    logic      alu_go;
    logic      mul_go;
    logic      alu_free;
    logic      alu_grant;
    wb_t       alu_res;
    wb_t       mul_res;

    reg_manage u_reg_manage (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue),
        .issue_inst    (issue_inst),
        .branch_hazard (branch_hazard),
        .hazard_ctx    (hazard_ctx),
        .alu_free      (alu_free),
        .wb            (wb),
        .accepted      (accepted),
        .rf_addr1      (rf_addr1),
        .rf_addr2      (rf_addr2),
        .rf_data1      (rf_data1),
        .rf_data2      (rf_data2),
        .ex_req        (ex_req),
        .alu_go        (alu_go),
        .mul_go        (mul_go)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rd_addr1 (rf_addr1),
        .rd_addr2 (rf_addr2),
        .rd_data1 (rf_data1),
        .rd_data2 (rf_data2),
        .wr       (wb)
    );

    alu_unit u_alu_unit (
        .clk           (clk),
        .rst           (rst),
        .go            (alu_go),
        .req           (ex_req),
        .branch_hazard (branch_hazard),
        .hazard_ctx    (hazard_ctx),
        .grant         (alu_grant),
        .res           (alu_res),
        .free          (alu_free)
    );

    mul_unit u_mul_unit (
        .clk           (clk),
        .rst           (rst),
        .go            (mul_go),
        .req           (ex_req),
        .branch_hazard (branch_hazard),
        .hazard_ctx    (hazard_ctx),
        .res           (mul_res)
    );

    wb_arbiter u_wb_arbiter (
        .alu_res   (alu_res),
        .mul_res   (mul_res),
        .alu_grant (alu_grant),
        .wb        (wb)
    );

endmodule

// ==== sim/tb_reg_subsys.sv ====
`timescale 1ns/100ps
`include "rm_config.svh"

module tb_reg_subsys;
    import reg_types_pkg::*;
    import exec_pkg::*;

    // one expected writeback and the cycle it is due in
    typedef struct packed {
        wb_t  w;
        ctx_t ctx;
        int   due;
    } exp_t;

    logic   clk;
    logic   rst;
    logic   issue;
    issue_t issue_inst;
    logic   branch_hazard;
    ctx_t   hazard_ctx;
    logic   accepted;
    wb_t    wb;

    word_t  shadow [`RM_NREG];
    exp_t   exp_q [$];
    op_e    alu_ops [5] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SLL};
    int     cyc = 0;
    int     last_alu_due = 0;
    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     err_mark = 0;
    word_t  load_val;
    logic   load_on;

    reg_subsys_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue),
        .issue_inst    (issue_inst),
        .branch_hazard (branch_hazard),
        .hazard_ctx    (hazard_ctx),
        .accepted      (accepted),
        .wb            (wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // rising edges seen so far
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic word_t ref_result(input op_e op, input word_t a, input word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_MUL:  return a * b;
            default: return '0;
        endcase
    endfunction

    // any result already booked for this wb cycle is a product
    function automatic logic slot_taken(input int slot);
        foreach (exp_q[i]) begin
            if (exp_q[i].due == slot) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_wb(input wb_t got, input wb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t wb: got %b/x%0d/%h expected %b/x%0d/%h",
                     $time, got.valid, got.rd, got.data, exp.valid, exp.rd, exp.data);
        end
    endtask

    task automatic check_accept(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t accepted: got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic record_expect(input issue_t inst);
        exp_t  e;
        word_t a;
        word_t b;
        int    slot;
        int    pos;
        a = load_on ? load_val : shadow[inst.rs1];
        b = shadow[inst.rs2];
        e.w = '{valid: 1'b1, rd: inst.rd, data: ref_result(inst.op, a, b)};
        e.ctx = inst.ctx;
        if (inst.op == OP_MUL) begin
            e.due = cyc + 3;
        end else begin
            // alu waits behind every product on the bus
            slot = cyc + 1;
            while (slot_taken(slot)) begin
                slot++;
            end
            e.due = slot;
            last_alu_due = slot;
        end
        pos = 0;
        while (pos < exp_q.size() && exp_q[pos].due < e.due) begin
            pos++;
        end
        exp_q.insert(pos, e);
    endtask

    // drive at a falling edge, retry until accepted
    task automatic send(input op_e op, input reg_addr_t rd, input reg_addr_t rs1,
                        input reg_addr_t rs2, input ctx_t ctx, input int first_ok,
                        output int acc_cyc);
        int tries;
        tries = 0;
        acc_cyc = -1;
        issue = 1'b1;
        issue_inst = '{use_rs1: 1'b1, rs1: rs1, use_rs2: 1'b1, rs2: rs2,
                       use_rd: 1'b1, rd: rd, ctx: ctx, op: op};
        while (acc_cyc < 0 && tries < 50) begin
            #10;
            check_accept(accepted, cyc >= first_ok);
            if (accepted) begin
                record_expect(issue_inst);
                acc_cyc = cyc;
            end
            @(negedge clk);
            tries++;
        end
        issue = 1'b0;
        if (acc_cyc < 0) begin
            errors++;
            $display("ERROR t=%0t writer of x%0d not accepted within 50 cycles", $time, rd);
        end
    endtask

    // x0 read port overridden so the add carries a chosen value
    task automatic load_reg(input reg_addr_t rd, input word_t val);
        int acc;
        load_val = val;
        load_on = 1'b1;
        force dut0.rf_data1 = load_val;
        send(OP_ADD, rd, 4'd0, 4'd0, 4'b0001, 0, acc);
        release dut0.rf_data1;
        load_on = 1'b0;
    endtask

    // in-flight results of the flushed context never reach wb
    task automatic drop_flushed(input ctx_t mask);
        int i;
        i = 0;
        while (i < exp_q.size()) begin
            if (exp_q[i].due > cyc && (exp_q[i].ctx & mask) != '0) begin
                exp_q.delete(i);
            end else begin
                i++;
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        @(negedge clk);
        if (exp_q.size() > 0) begin
            errors++;
            $display("ERROR t=%0t %0d writebacks still missing after 50 cycles",
                     $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // wb is registered, so the falling edge sees it settled
    initial begin : wb_monitor
        exp_t head;
        forever begin
            @(negedge clk);
            if (!rst && wb.valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR t=%0t writeback to x%0d with nothing outstanding",
                             $time, wb.rd);
                end else begin
                    head = exp_q.pop_front();
                    check_wb(wb, head.w);
                    if (head.due != cyc) begin
                        errors++;
                        $display("ERROR t=%0t x%0d written in cycle %0d, due in cycle %0d",
                                 $time, head.w.rd, cyc, head.due);
                    end
                    shadow[head.w.rd] = head.w.data;
                end
            end else if (!rst && exp_q.size() > 0 && exp_q[0].due <= cyc) begin
                head = exp_q.pop_front();
                errors++;
                $display("ERROR t=%0t no writeback for x%0d due in cycle %0d",
                         $time, head.w.rd, head.due);
            end
        end
    end

    initial begin
        int acc;
        int k;
        int pend;
        int r;
        reg_addr_t s1;
        reg_addr_t s2;
        rst = 1'b1;
        issue = 1'b0;
        issue_inst = '0;
        branch_hazard = 1'b0;
        hazard_ctx = '0;
        load_val = '0;
        load_on = 1'b0;
        for (r = 0; r < `RM_NREG; r++) begin
            shadow[r] = '0;
        end
        void'($urandom(32'ha62990d3));
        repeat (4) @(negedge clk);
        rst = 1'b0;

        for (r = 1; r <= 6; r++) begin
            load_reg(reg_addr_t'(r), $urandom());
        end
        drain();
        for (r = 0; r < 5; r++) begin
            s1 = reg_addr_t'($urandom_range(6, 1));
            s2 = reg_addr_t'($urandom_range(6, 1));
            send(alu_ops[r], reg_addr_t'(7 + r), s1, s2, 4'b0001, 0, acc);
        end
        drain();
        report_test("alu on random operands");

        for (r = 0; r < 4; r++) begin
            send(OP_MUL, reg_addr_t'(12 + r), reg_addr_t'(1 + r), reg_addr_t'(2 + r),
                 4'b0010, 0, acc);
        end
        drain();
        report_test("back to back multiply");

        // consumer gets in on the producer's wb cycle
        send(OP_MUL, 4'd8, 4'd1, 4'd3, 4'b0001, 0, acc);
        send(OP_ADD, 4'd9, 4'd8, 4'd4, 4'b0001, acc + 3, k);
        drain();
        report_test("read after write");

        send(OP_MUL, 4'd10, 4'd2, 4'd5, 4'b0001, 0, acc);
        send(OP_XOR, 4'd10, 4'd3, 4'd6, 4'b0001, acc + 3, k);
        drain();
        report_test("write after write");

        // x11 product killed in stage 1 while x12 survives
        send(OP_MUL, 4'd11, 4'd1, 4'd2, 4'b0001, 0, acc);
        send(OP_MUL, 4'd12, 4'd3, 4'd4, 4'b0010, 0, k);
        branch_hazard = 1'b1;
        hazard_ctx = 4'b0001;
        drop_flushed(4'b0001);
        send(OP_SUB, 4'd11, 4'd5, 4'd6, 4'b0100, 0, k);
        // a new instruction in the flushed context is refused
        issue_inst = '{use_rs1: 1'b1, rs1: 4'd1, use_rs2: 1'b1, rs2: 4'd2,
                       use_rd: 1'b1, rd: 4'd13, ctx: 4'b0001, op: OP_ADD};
        issue = 1'b1;
        #10;
        check_accept(accepted, 1'b0);
        @(negedge clk);
        issue = 1'b0;
        branch_hazard = 1'b0;
        hazard_ctx = '0;
        drain();
        report_test("branch flush");

        send(OP_MUL, 4'd8, 4'd1, 4'd2, 4'b0001, 0, acc);
        send(OP_MUL, 4'd9, 4'd3, 4'd4, 4'b0001, 0, k);
        send(OP_AND, 4'd10, 4'd5, 4'd6, 4'b0001, 0, k);
        pend = last_alu_due;
        send(OP_MUL, 4'd12, 4'd2, 4'd3, 4'b0001, 0, k);
        // refused until the held result is granted
        send(OP_ADD, 4'd13, 4'd1, 4'd6, 4'b0001, pend, k);
        drain();
        report_test("writeback collision");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/exec_pkg.sv
logic/reg_types_pkg.sv
logic/reg_file.sv
logic/reg_manage.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/wb_arbiter.sv
logic/reg_subsys_top.sv
sim/tb_reg_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the register subsystem testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_reg_subsys

verilator --binary --timing --timescale 1ns/100ps \
    -f filelist.f --top-module "$TOP" --Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx ">>> PASS" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
